// ==== sim.f ====
design/cpuPkg.sv
design/memMapPkg.sv
design/accessIf.sv
design/memReg.sv
design/addrCheck.sv
design/storeFormat.sv
design/dataRam.sv
design/loadAlign.sv
design/memStage.sv
verif/memStage_assertions.sv
verif/memStageTb.sv

// ==== Makefile ====
TOP := memStageTb
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) +verilator+error+limit+10

clean:
	rm -rf $(OBJ)

// ==== verif/memStageTb.sv ====
/*
 * memStageTb: random loads and stores through the memory stage, checked
 * against a word-array model and a queue of expected retire records
 */
`timescale 1ns/1ps

module memStageTb;
    import cpuPkg::*;
    import memMapPkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_ACCESSES = 2000;
    localparam int          LOAD_PREFIX  = 16;  // loads of the still-zero RAM first
    localparam int          WATCHDOG_NS  = (RESET_CYCLES + 2 * NUM_ACCESSES + 100) * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'h684387cb;

    typedef struct {
        int       due;      // cycle in which doneValid is expected
        logic     wbEn;
        logic     excValid;
        regIdx_t  wbDst;
        word_t    wbData;
        excCode_t excCode;
        addr_t    badVAddr;
    } retire_t;

    logic     clk;
    logic     arstN;
    logic     inValid;
    memOp_t   inOp;
    addr_t    inAddr;
    word_t    inStoreData;
    regIdx_t  inDst;
    logic     flush;
    logic     doneValid;
    logic     wbEn;
    regIdx_t  wbDst;
    word_t    wbData;
    logic     excValid;
    excCode_t excCode;
    addr_t    badVAddr;

    word_t   model [RAM_WORDS];
    retire_t pendingRetires [$];
    int      cycle = 0;

    // item now sitting in the address stage
    logic    pendValid = 1'b0;
    memOp_t  pendOp;
    addr_t   pendAddr;
    word_t   pendData;
    regIdx_t pendDst;

    memStage uut (
        .clk         (clk),
        .arstN       (arstN),
        .inValid     (inValid),
        .inOp        (inOp),
        .inAddr      (inAddr),
        .inStoreData (inStoreData),
        .inDst       (inDst),
        .flush       (flush),
        .doneValid   (doneValid),
        .wbEn        (wbEn),
        .wbDst       (wbDst),
        .wbData      (wbData),
        .excValid    (excValid),
        .excCode     (excCode),
        .badVAddr    (badVAddr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic failRun();
        $display("Testbench failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compareField(string name, logic [31:0] expVal, logic [31:0] actVal);
        assert (actVal === expVal) else begin
            $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h",
                     $time, name, expVal, actVal);
            failRun();
        end
    endtask

    function automatic logic isStoreOp(memOp_t op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

    function automatic int accessBytes(memOp_t op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            default:              return 4;
        endcase
    endfunction

    // only kseg0 and kseg1 lose their segment bits
    function automatic addr_t physAddr(addr_t va);
        if (va[31:29] == KSEG0_BASE[31:29] || va[31:29] == KSEG1_BASE[31:29]) begin
            return {3'b000, va[28:0]};
        end
        return va;
    endfunction

    function automatic word_t loadValue(memOp_t op, word_t w, logic [1:0] lo);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*lo +: 8];
        h = lo[1] ? w[31:16] : w[15:0];
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'h0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    function automatic memOp_t randomLoadOp();
        case ($urandom_range(0, 4))
            0:       return OP_LB;
            1:       return OP_LBU;
            2:       return OP_LH;
            3:       return OP_LHU;
            default: return OP_LW;
        endcase
    endfunction

    function automatic addr_t randomAddr(memOp_t op);
        logic [2:0] seg;
        logic [7:0] idx;
        logic [1:0] lo;
        case ($urandom_range(0, 3))
            0:       seg = {1'b0, 2'($urandom_range(0, 3))}; // kuseg
            1:       seg = 3'b100;                            // kseg0
            2:       seg = 3'b101;                            // kseg1
            default: seg = 3'b110;                            // kseg2, no translation
        endcase
        // a small hot set so stores and loads meet often
        idx = ($urandom_range(0, 3) == 0) ? 8'($urandom_range(0, 255))
                                          : 8'($urandom_range(0, 15));
        lo = 2'($urandom_range(0, 3));
        if ($urandom_range(0, 7) != 0) begin
            if (accessBytes(op) == 4) begin
                lo = 2'b00;
            end else if (accessBytes(op) == 2) begin
                lo[0] = 1'b0;
            end
        end
        return {seg, 19'($urandom), idx, lo};
    endfunction

    // apply an unflushed address-stage item to the model and queue its retire
    task automatic applyAccess();
        retire_t  rec;
        int       nBytes;
        int       lane;
        logic     misaligned;
        addr_t    pa;
        logic [7:0] idx;
        nBytes     = accessBytes(pendOp);
        misaligned = (nBytes == 2 && pendAddr[0]) || (nBytes == 4 && pendAddr[1:0] != 2'b00);
        pa         = physAddr(pendAddr);
        idx        = pa[9:2];
        rec.due      = cycle + 2;
        rec.wbEn     = !misaligned && !isStoreOp(pendOp);
        rec.excValid = misaligned;
        rec.wbDst    = pendDst;
        rec.wbData   = loadValue(pendOp, model[idx], pendAddr[1:0]);
        rec.excCode  = isStoreOp(pendOp) ? EXC_ADES : EXC_ADEL;
        rec.badVAddr = pendAddr;
        if (isStoreOp(pendOp) && !misaligned) begin
            for (int b = 0; b < nBytes; b++) begin
                lane = int'(pendAddr[1:0]) + b;
                model[idx][8*lane +: 8] = pendData[8*b +: 8];
            end
        end
        pendingRetires.push_back(rec);
    endtask

    task automatic stepCycle(logic strobe, logic loadsOnly);
        @(posedge clk);
        #2;
        flush = ($urandom_range(0, 15) == 0);
        if (pendValid && !flush) begin
            applyAccess();
        end
        inOp        = loadsOnly ? randomLoadOp() : memOp_t'($urandom_range(0, 7));
        inAddr      = randomAddr(inOp);
        inStoreData = $urandom;
        inDst       = regIdx_t'($urandom_range(0, 31));
        inValid     = strobe; // payload still toggles on idle cycles
        pendValid   = strobe;
        pendOp      = inOp;
        pendAddr    = inAddr;
        pendData    = inStoreData;
        pendDst     = inDst;
    endtask

    task automatic checkRetire();
        retire_t rec;
        assert (uut.uAssertions.anyFailed == 1'b0) else begin
            $display("a bound protocol assertion fired before t=%0t", $time);
            failRun();
        end
        if (pendingRetires.size() != 0 && pendingRetires[0].due == cycle) begin
            rec = pendingRetires.pop_front();
            compareField("doneValid", 32'd1, 32'(doneValid));
            compareField("wbEn", 32'(rec.wbEn), 32'(wbEn));
            compareField("excValid", 32'(rec.excValid), 32'(excValid));
            if (rec.wbEn) begin
                compareField("wbDst", 32'(rec.wbDst), 32'(wbDst));
                compareField("wbData", rec.wbData, wbData);
            end
            if (rec.excValid) begin
                compareField("excCode", 32'(rec.excCode), 32'(excCode));
                compareField("badVAddr", rec.badVAddr, badVAddr);
            end
        end else begin
            compareField("doneValid", 32'd0, 32'(doneValid));
            compareField("wbEn", 32'd0, 32'(wbEn));
            compareField("excValid", 32'd0, 32'(excValid));
        end
    endtask

    always @(negedge clk) checkRetire(); // mid-cycle, outputs settled

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired with %0d retires outstanding", pendingRetires.size());
        failRun();
    end

    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < RAM_WORDS; i++) begin
            model[i] = '0;
        end
        arstN       = 1'b0;
        inValid     = 1'b0;
        flush       = 1'b0;
        inOp        = OP_LW;
        inAddr      = '0;
        inStoreData = '0;
        inDst       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arstN = 1'b1;
        for (int n = 0; n < NUM_ACCESSES; n++) begin
            if ($urandom_range(0, 7) == 0) begin
                stepCycle(1'b0, 1'b0); // occasional bubble
            end
            stepCycle(1'b1, n < LOAD_PREFIX);
        end
        stepCycle(1'b0, 1'b0); // last item through the address stage
        @(posedge clk);
        #2;
        flush = 1'b0; // address stage empty from here on
        while (pendingRetires.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verif/memStage_assertions.sv ====
/*
 * memStageAssertions: retire protocol and latency checks bound to memStage
 */
`timescale 1ns/1ps

module memStageAssertions (
    input logic clk,
    input logic arstN,
    input logic inValid,
    input logic flush,
    input logic doneValid,
    input logic wbEn,
    input logic excValid
);
    bit anyFailed = 1'b0; // polled by the testbench

    wbImpliesDone: assert property (@(posedge clk) disable iff (!arstN) wbEn |-> doneValid)
        else begin
            $error("wbEn without doneValid");
            anyFailed = 1'b1;
        end

    excImpliesDone: assert property (@(posedge clk) disable iff (!arstN) excValid |-> doneValid)
        else begin
            $error("excValid without doneValid");
            anyFailed = 1'b1;
        end

    wbExcExclusive: assert property (@(posedge clk) disable iff (!arstN) !(wbEn && excValid))
        else begin
            $error("wbEn and excValid both high");
            anyFailed = 1'b1;
        end

    // strobe sampled, flush one edge later, retire three edges later
    fixedLatency: assert property (@(posedge clk) disable iff (!arstN)
            doneValid == ($past(inValid, 3) && !$past(flush, 2)))
        else begin
            $error("doneValid does not match an unflushed strobe three edges back");
            anyFailed = 1'b1;
        end

    quietInReset: assert property (@(posedge clk)
            !arstN |-> (!doneValid && !wbEn && !excValid))
        else begin
            $error("retire outputs high during reset");
            anyFailed = 1'b1;
        end

endmodule

bind memStage memStageAssertions uAssertions (
    .clk       (clk),
    .arstN     (arstN),
    .inValid   (inValid),
    .flush     (flush),
    .doneValid (doneValid),
    .wbEn      (wbEn),
    .excValid  (excValid)
);

// ==== design/memStage.sv ====
/*
 * memStage: data-memory stage top, input register, address check,
 * store formatting, data RAM and load alignment in a three-edge pipeline
 */
`timescale 1ns/1ps

module memStage (
    input  logic               clk,
    input  logic               arstN,
    input  logic               inValid,
    input  cpuPkg::memOp_t     inOp,
    input  cpuPkg::addr_t      inAddr,
    input  cpuPkg::word_t      inStoreData,
    input  cpuPkg::regIdx_t    inDst,
    input  logic               flush,
    output logic               doneValid,
    output logic               wbEn,
    output cpuPkg::regIdx_t    wbDst,
    output cpuPkg::word_t      wbData,
    output logic               excValid,
    output cpuPkg::excCode_t   excCode,
    output cpuPkg::addr_t      badVAddr
);
    import cpuPkg::*;
    import memMapPkg::*;

    logic     fault;
    excCode_t faultCode;    // cause picked in the address stage
    ramIdx_t  physIdx;
    logic     storeEn;
    byteEn_t  wrStrobe;
    word_t    wrData;
    word_t    rdData;

    accessIf acc ();

    memReg uMemReg (
        .clk         (clk),
        .arstN       (arstN),
        .flush       (flush),
        .inValid     (inValid),
        .inOp        (inOp),
        .inAddr      (inAddr),
        .inStoreData (inStoreData),
        .inDst       (inDst),
        .acc         (acc.src)
    );

    addrCheck uAddrCheck (
        .acc     (acc.sink),
        .fault   (fault),
        .excCode (faultCode),
        .physIdx (physIdx),
        .storeEn (storeEn)
    );

    storeFormat uStoreFormat (
        .acc      (acc.sink),
        .storeEn  (storeEn),
        .wrStrobe (wrStrobe),
        .wrData   (wrData)
    );

    dataRam uDataRam (
        .clk      (clk),
        .idx      (physIdx),
        .wrStrobe (wrStrobe),
        .wrData   (wrData),
        .rdData   (rdData)
    );

    loadAlign uLoadAlign (
        .clk       (clk),
        .arstN     (arstN),
        .acc       (acc.sink),
        .fault     (fault),
        .excCode   (faultCode),
        .rdData    (rdData),
        .doneValid (doneValid),
        .wbEn      (wbEn),
        .excValid  (excValid),
        .wbDst     (wbDst),
        .wbData    (wbData),
        .excOut    (excCode),
        .badVAddr  (badVAddr)
    );

endmodule

// ==== design/loadAlign.sv ====
/*
 * loadAlign: second-stage control register, load byte/halfword extraction
 * with sign or zero extension, and the retire register
 */
`timescale 1ns/1ps

module loadAlign (
    input  logic               clk,
    input  logic               arstN,
    accessIf.sink              acc,
    input  logic               fault,
    input  cpuPkg::excCode_t   excCode,
    input  cpuPkg::word_t      rdData,
    output logic               doneValid,
    output logic               wbEn,
    output logic               excValid,
    output cpuPkg::regIdx_t    wbDst,
    output cpuPkg::word_t      wbData,
    output cpuPkg::excCode_t   excOut,
    output cpuPkg::addr_t      badVAddr
);
    import cpuPkg::*;

    logic       s2Valid;
    memOp_t     s2Op;
    logic [1:0] s2Lo;
    addr_t      s2VAddr;
    regIdx_t    s2Dst;
    logic       s2Fault;
    excCode_t   s2ExcCode;
    word_t      shifted;
    word_t      loadVal;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s2Valid <= 1'b0;
        end else begin
            s2Valid <= acc.valid;
        end
    end

    // control travels alongside the RAM read
    always_ff @(posedge clk) begin
        s2Op      <= acc.op;
        s2Lo      <= acc.vaddr[1:0];
        s2VAddr   <= acc.vaddr;
        s2Dst     <= acc.dst;
        s2Fault   <= fault;
        s2ExcCode <= excCode;
    end

    assign shifted = rdData >> {s2Lo, 3'b000}; // addressed lane down to bit 0

    always_comb begin
        unique case (opSize(s2Op))
            SZ_BYTE: loadVal = opIsUnsigned(s2Op) ? {24'b0, shifted[7:0]}
                                                  : {{24{shifted[7]}}, shifted[7:0]};
            SZ_HALF: loadVal = opIsUnsigned(s2Op) ? {16'b0, shifted[15:0]}
                                                  : {{16{shifted[15]}}, shifted[15:0]};
            default: loadVal = rdData;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            doneValid <= 1'b0;
            wbEn      <= 1'b0;
            excValid  <= 1'b0;
            wbDst     <= '0;
            wbData    <= '0;
            excOut    <= '0;
            badVAddr  <= '0;
        end else begin
            doneValid <= s2Valid;
            wbEn      <= s2Valid & ~s2Fault & ~opIsStore(s2Op); // loads only
            excValid  <= s2Valid & s2Fault;
            wbDst     <= s2Dst;
            wbData    <= loadVal;
            excOut    <= s2ExcCode;
            badVAddr  <= s2VAddr; // virtual, as seen by software
        end
    end

endmodule

// ==== design/dataRam.sv ====
/*
 * dataRam: single-port synchronous word RAM with per-byte write strobes,
 * read data registered one cycle after the index
 */
`timescale 1ns/1ps

module dataRam (
    input  logic                clk,
    input  memMapPkg::ramIdx_t  idx,
    input  cpuPkg::byteEn_t     wrStrobe,
    input  cpuPkg::word_t       wrData,
    output cpuPkg::word_t       rdData
);
    import cpuPkg::*;
    import memMapPkg::*;

    word_t mem [RAM_WORDS];

    // start from a zeroed array
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wrStrobe[b]) begin
                mem[idx][8*b +: 8] <= wrData[8*b +: 8];
            end
        end
        rdData <= mem[idx]; // old word on a same-edge write
    end

endmodule

// ==== design/storeFormat.sv ====
/*
 * storeFormat: byte strobes and lane-replicated write data for
 * little-endian byte, halfword and word stores
 */
`timescale 1ns/1ps

module storeFormat (
    accessIf.sink              acc,
    input  logic               storeEn,
    output cpuPkg::byteEn_t    wrStrobe,
    output cpuPkg::word_t      wrData
);
    import cpuPkg::*;

    logic [1:0] lane;
    byteEn_t    strobe;

    assign lane = acc.vaddr[1:0];

    always_comb begin
        unique case (opSize(acc.op))
            SZ_BYTE: begin
                wrData = {4{acc.storeData[7:0]}};
                strobe = byteEn_t'(4'b0001 << lane);
            end
            SZ_HALF: begin
                wrData = {2{acc.storeData[15:0]}};
                strobe = lane[1] ? 4'b1100 : 4'b0011; // upper or lower half
            end
            default: begin
                wrData = acc.storeData;
                strobe = 4'b1111;
            end
        endcase
    end

    assign wrStrobe = storeEn ? strobe : '0; // no write for loads or faults

endmodule

// ==== design/addrCheck.sv ====
/*
 * addrCheck: alignment fault detection and kseg0/kseg1 translation,
 * produces the RAM word index and the store enable
 */
`timescale 1ns/1ps

module addrCheck (
    accessIf.sink               acc,
    output logic                fault,
    output cpuPkg::excCode_t    excCode,
    output memMapPkg::ramIdx_t  physIdx,
    output logic                storeEn
);
    import cpuPkg::*;
    import memMapPkg::*;

    memSize_t size;
    logic     isStore;
    logic     inKseg;
    addr_t    physAddr;

    always_comb begin
        size    = opSize(acc.op);
        isStore = opIsStore(acc.op);

        unique case (size)
            SZ_HALF: fault = acc.vaddr[0];
            SZ_WORD: fault = |acc.vaddr[1:0];
            default: fault = 1'b0; // bytes never misalign
        endcase

        excCode = isStore ? EXC_ADES : EXC_ADEL;
    end

    // unmapped kernel segments just drop the segment bits
    assign inKseg   = (acc.vaddr[31 -: SEG_BITS] == KSEG0_BASE[31 -: SEG_BITS]) ||
                      (acc.vaddr[31 -: SEG_BITS] == KSEG1_BASE[31 -: SEG_BITS]);
    assign physAddr = inKseg ? (acc.vaddr & ~SEG_MASK) : acc.vaddr;
    assign physIdx  = physAddr[RAM_IDX_LSB +: RAM_IDX_BITS];

    assign storeEn = acc.valid & isStore & ~fault;

endmodule

// ==== design/memReg.sv ====
/*
 * memReg: input register of the memory stage, holds the access in the
 * address stage and drops it when flush is raised
 */
`timescale 1ns/1ps

module memReg (
    input  logic             clk,
    input  logic             arstN,
    input  logic             flush,
    input  logic             inValid,
    input  cpuPkg::memOp_t   inOp,
    input  cpuPkg::addr_t    inAddr,
    input  cpuPkg::word_t    inStoreData,
    input  cpuPkg::regIdx_t  inDst,
    accessIf.src             acc
);
    import cpuPkg::*;

    logic    validQ;
    memOp_t  opQ;
    addr_t   addrQ;
    word_t   storeDataQ;
    regIdx_t dstQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inValid;
        end
    end

    // payload only loads on a strobe
    always_ff @(posedge clk) begin
        if (inValid) begin
            opQ        <= inOp;
            addrQ      <= inAddr;
            storeDataQ <= inStoreData;
            dstQ       <= inDst;
        end
    end

    assign acc.valid     = validQ & ~flush; // killed item never advances
    assign acc.op        = opQ;
    assign acc.vaddr     = addrQ;
    assign acc.storeData = storeDataQ;
    assign acc.dst       = dstQ;

endmodule

// ==== design/accessIf.sv ====
/*
 * accessIf: one registered load or store travelling from the input
 * register to the address, store-format and load-align blocks
 */
`timescale 1ns/1ps

interface accessIf;
    import cpuPkg::*;

    logic    valid;
    memOp_t  op;
    addr_t   vaddr;
    word_t   storeData;
    regIdx_t dst;

    modport src  (output valid, op, vaddr, storeData, dst);
    modport sink (input  valid, op, vaddr, storeData, dst);

endinterface

// ==== design/memMapPkg.sv ====
/*
 * memMapPkg: kernel segment bases and on-chip data RAM sizing
 */
package memMapPkg;

    // kseg0 cached, kseg1 uncached, both unmapped
    localparam cpuPkg::addr_t KSEG0_BASE = 32'h8000_0000;
    localparam cpuPkg::addr_t KSEG1_BASE = 32'hA000_0000;

    localparam int            SEG_BITS = 3;            // segment select width
    localparam cpuPkg::addr_t SEG_MASK = 32'hE000_0000; // bits cleared on translation

    localparam int RAM_WORDS    = 256;
    localparam int RAM_IDX_BITS = $clog2(RAM_WORDS);
    localparam int RAM_IDX_LSB  = 2; // word addressed

    typedef logic [RAM_IDX_BITS-1:0] ramIdx_t;

endpackage

// ==== design/cpuPkg.sv ====
/*
 * cpuPkg: core data types, memory operation codes and exception causes
 * shared by the data-memory stage
 */
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [2:0]  memOp_t;
    typedef logic [1:0]  memSize_t;
    typedef logic [3:0]  byteEn_t;
    typedef logic [4:0]  excCode_t;

    // access size, low two bits of a memOp_t
    localparam memSize_t SZ_BYTE = 2'b00;
    localparam memSize_t SZ_HALF = 2'b01;
    localparam memSize_t SZ_WORD = 2'b10;

    // loads keep bit 2 clear, stores set it; the unsigned halfword load
    // takes the one code with bit 2 set that is not a store
    localparam memOp_t OP_LB  = 3'b000;
    localparam memOp_t OP_LH  = 3'b001;
    localparam memOp_t OP_LW  = 3'b010;
    localparam memOp_t OP_LBU = 3'b011;
    localparam memOp_t OP_SB  = 3'b100;
    localparam memOp_t OP_SH  = 3'b101;
    localparam memOp_t OP_SW  = 3'b110;
    localparam memOp_t OP_LHU = 3'b111;

    localparam excCode_t EXC_ADEL = 5'd4; // address error on load
    localparam excCode_t EXC_ADES = 5'd5; // address error on store

    function automatic logic opIsStore(memOp_t op);
        return op[2] && (op != OP_LHU);
    endfunction

    function automatic logic opIsUnsigned(memOp_t op);
        return (op == OP_LBU) || (op == OP_LHU);
    endfunction

    function automatic memSize_t opSize(memOp_t op);
        if (op == OP_LBU) return SZ_BYTE;
        if (op == OP_LHU) return SZ_HALF;
        return op[1:0];
    endfunction

endpackage
